/* src/board_config.svh */
`ifndef BOARD_CONFIG_SVH
`define BOARD_CONFIG_SVH

// Address map of the board bus
`define ROM_BASE 64'h0000_0000_0000_0000
`define RAM_BASE 64'h0000_0000_0000_1000
`define ART_BASE 64'h0000_0000_0000_2000
`define KEY_BASE 64'h0000_0000_0000_2008

// Unified memory depth in 32-bit words (8 KB)
`define MEM_WORDS 2048

// Equal PS/2 clock samples needed before a level is accepted
`define PS2_FILTER_LEN 8

`endif

/* src/board_pkg.sv */
`default_nettype none

package board_pkg;

    // Data bus word of the core
    typedef logic [63:0] word_t;

    // Bus and fetch address
    typedef logic [63:0] addr_t;

    // One memory location
    typedef logic [31:0] mem_word_t;

    // Raw set-2 scan code
    typedef logic [7:0] scan_code_t;

    // Translated character
    typedef logic [7:0] ascii_t;

    typedef logic [3:0] irq_vector_t;

endpackage

`default_nettype wire

/* src/bus_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface bus_if;

    board_pkg::addr_t address;
    board_pkg::word_t write_data;
    logic             write_enable;
    logic             read_enable;
    // Registered, valid the cycle after read_enable
    board_pkg::word_t read_data;

    modport initiator (
        output address,
        output write_data,
        output write_enable,
        output read_enable,
        input  read_data
    );

    modport target (
        input  address,
        input  write_data,
        input  write_enable,
        input  read_enable,
        output read_data
    );

endinterface

`default_nettype wire

/* src/unified_memory.sv */
`timescale 1ns/10ps
`default_nettype none

`include "board_config.svh"

module unified_memory (
    input  logic                  CLOCK_50,
    input  board_pkg::addr_t      fetch_pc,
    output board_pkg::mem_word_t  instruction,
    bus_if.target                 bus
);

    localparam int INDEX_BITS = $clog2(`MEM_WORDS);

    board_pkg::mem_word_t mem [0:`MEM_WORDS-1];
    board_pkg::mem_word_t fetch_word;

    logic [INDEX_BITS-1:0] fetch_index;
    logic [INDEX_BITS-1:0] data_index;

    // Word addressing, byte offset bits dropped
    assign fetch_index = fetch_pc[INDEX_BITS+1:2];
    assign data_index  = bus.address[INDEX_BITS+1:2];

    // Contents start cleared, programs arrive over the bus
    initial begin
        for (int i = 0; i < `MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // Fetch port, one new pc per cycle
    always_ff @(posedge CLOCK_50) begin
        fetch_word <= mem[fetch_index];
    end

    // Instructions are stored big-endian, the core wants little-endian
    assign instruction = {fetch_word[7:0], fetch_word[15:8],
                          fetch_word[23:16], fetch_word[31:24]};

    // Data port, low half of the bus word only
    always_ff @(posedge CLOCK_50) begin
        if (bus.write_enable) begin
            mem[data_index] <= bus.write_data[31:0];
        end else if (bus.read_enable) begin
            bus.read_data <= {32'd0, mem[data_index]};
        end
    end

endmodule

`default_nettype wire

/* src/ps2_keyboard_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "board_config.svh"

module ps2_keyboard_decoder (
    input  logic                  CLOCK_50,
    input  logic                  KEY0,
    input  logic                  ps2_clk,
    input  logic                  ps2_data,
    output board_pkg::scan_code_t scan_code,
    output board_pkg::ascii_t     ascii_code,
    output logic                  key_pressed,
    output logic                  key_released
);

    localparam board_pkg::scan_code_t BREAK_PREFIX = 8'hF0;
    localparam logic [3:0]            LAST_BIT     = 4'd10;

    logic [1:0]                  clk_sync;
    logic [1:0]                  data_sync;
    logic [`PS2_FILTER_LEN-1:0]  clk_history;
    logic                        clk_filtered;
    logic                        clk_filtered_d;
    logic                        clk_fall;
    logic                        data_bit;
    logic [3:0]                  bit_count;
    logic [9:0]                  shift_reg;
    logic [10:0]                 frame;
    logic                        frame_ok;
    logic                        break_pending;
    board_pkg::scan_code_t       rx_byte;

    // Set-2 make codes to lower case ASCII
    function automatic board_pkg::ascii_t to_ascii(input board_pkg::scan_code_t code);
        case (code)
            8'h1C: to_ascii = "a";
            8'h32: to_ascii = "b";
            8'h21: to_ascii = "c";
            8'h23: to_ascii = "d";
            8'h24: to_ascii = "e";
            8'h2B: to_ascii = "f";
            8'h34: to_ascii = "g";
            8'h33: to_ascii = "h";
            8'h43: to_ascii = "i";
            8'h3B: to_ascii = "j";
            8'h42: to_ascii = "k";
            8'h4B: to_ascii = "l";
            8'h3A: to_ascii = "m";
            8'h31: to_ascii = "n";
            8'h44: to_ascii = "o";
            8'h4D: to_ascii = "p";
            8'h15: to_ascii = "q";
            8'h2D: to_ascii = "r";
            8'h1B: to_ascii = "s";
            8'h2C: to_ascii = "t";
            8'h3C: to_ascii = "u";
            8'h2A: to_ascii = "v";
            8'h1D: to_ascii = "w";
            8'h22: to_ascii = "x";
            8'h35: to_ascii = "y";
            8'h1A: to_ascii = "z";
            8'h45: to_ascii = "0";
            8'h16: to_ascii = "1";
            8'h1E: to_ascii = "2";
            8'h26: to_ascii = "3";
            8'h25: to_ascii = "4";
            8'h2E: to_ascii = "5";
            8'h36: to_ascii = "6";
            8'h3D: to_ascii = "7";
            8'h3E: to_ascii = "8";
            8'h46: to_ascii = "9";
            8'h29: to_ascii = " ";
            8'h5A: to_ascii = 8'h0D;
            default: to_ascii = 8'h00;
        endcase
    endfunction

    // Synchronizers and clock glitch filter, both lines idle high
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            clk_sync       <= 2'b11;
            data_sync      <= 2'b11;
            clk_history    <= '1;
            clk_filtered   <= 1'b1;
            clk_filtered_d <= 1'b1;
        end else begin
            clk_sync    <= {clk_sync[0], ps2_clk};
            data_sync   <= {data_sync[0], ps2_data};
            clk_history <= {clk_history[`PS2_FILTER_LEN-2:0], clk_sync[1]};
            if (&clk_history) begin
                clk_filtered <= 1'b1;
            end else if (~|clk_history) begin
                clk_filtered <= 1'b0;
            end
            clk_filtered_d <= clk_filtered;
        end
    end

    assign clk_fall = clk_filtered_d & ~clk_filtered;
    assign data_bit = data_sync[1];

    // Bit 0 is the start bit, bit 9 parity, bit 10 stop
    assign frame    = {data_bit, shift_reg};
    assign rx_byte  = frame[8:1];
    assign frame_ok = clk_fall && (bit_count == LAST_BIT) && !frame[0] && frame[10]
                      && (^frame[9:1]);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bit_count     <= '0;
            break_pending <= 1'b0;
            key_pressed   <= 1'b0;
            key_released  <= 1'b0;
        end else begin
            key_pressed  <= 1'b0;
            key_released <= 1'b0;
            if (clk_fall) begin
                // Wait for a low start bit before counting
                if (bit_count == 4'd0) begin
                    if (!data_bit) begin
                        bit_count <= 4'd1;
                    end
                end else if (bit_count == LAST_BIT) begin
                    bit_count <= 4'd0;
                end else begin
                    bit_count <= bit_count + 4'd1;
                end
            end
            if (frame_ok) begin
                if (rx_byte == BREAK_PREFIX) begin
                    break_pending <= 1'b1;
                end else begin
                    break_pending <= 1'b0;
                    key_released  <= break_pending;
                    key_pressed   <= !break_pending;
                end
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (clk_fall) begin
            shift_reg <= {data_bit, shift_reg[9:1]};
        end
        if (frame_ok && rx_byte != BREAK_PREFIX) begin
            scan_code  <= rx_byte;
            ascii_code <= to_ascii(rx_byte);
        end
    end

endmodule

`default_nettype wire

/* src/interrupt_controller.sv */
`timescale 1ns/10ps
`default_nettype none

module interrupt_controller (
    input  logic                   CLOCK_50,
    input  logic                   KEY0,
    input  logic                   key_pressed,
    input  board_pkg::ascii_t      ascii_code,
    input  logic                   interrupt_ack,
    output board_pkg::irq_vector_t interrupt_vector,
    output board_pkg::ascii_t      key_ascii,
    output logic                   pending_led
);

    localparam board_pkg::irq_vector_t KEYBOARD_IRQ = 4'd1;

    logic key_event;

    // Keys without a printable mapping raise nothing
    assign key_event = key_pressed && (ascii_code != 8'h00);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            interrupt_vector <= '0;
            key_ascii        <= '0;
        end else begin
            // A new key outranks an ack in the same cycle
            if (key_event) begin
                interrupt_vector <= KEYBOARD_IRQ;
                key_ascii        <= ascii_code;
            end else if (interrupt_vector != '0 && interrupt_ack) begin
                interrupt_vector <= '0;
            end
        end
    end

    assign pending_led = (interrupt_vector != '0);

endmodule

`default_nettype wire

/* src/mmio_bus_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "board_config.svh"

module mmio_bus_decoder (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  board_pkg::addr_t  bus_address,
    input  board_pkg::word_t  bus_write_data,
    input  logic              bus_write_enable,
    input  logic              bus_read_enable,
    output board_pkg::word_t  bus_read_data,
    input  board_pkg::ascii_t key_ascii,
    bus_if.initiator          mem,
    output board_pkg::ascii_t uart_data,
    output logic              uart_strobe,
    output logic              key_select
);

    typedef enum logic [1:0] {
        SRC_NONE,
        SRC_MEM,
        SRC_KEY
    } read_src_t;

    read_src_t         read_src;
    board_pkg::ascii_t key_data;
    logic              rom_select;
    logic              ram_select;
    logic              mem_select;
    logic              art_select;
    logic              art_write;
    logic              art_write_d;

    // Offset compares, addresses below a base wrap to large values
    assign rom_select = (bus_address - `ROM_BASE) < (`RAM_BASE - `ROM_BASE);
    assign ram_select = (bus_address - `RAM_BASE) < (`ART_BASE - `RAM_BASE);
    assign mem_select = rom_select || ram_select;
    assign art_select = (bus_address == `ART_BASE);
    assign key_select = (bus_address == `KEY_BASE);

    assign mem.address      = bus_address;
    assign mem.write_data   = bus_write_data;
    assign mem.write_enable = bus_write_enable && mem_select;
    assign mem.read_enable  = bus_read_enable && mem_select;

    assign art_write = bus_write_enable && art_select;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            read_src    <= SRC_NONE;
            art_write_d <= 1'b0;
            uart_strobe <= 1'b0;
        end else begin
            if (bus_read_enable) begin
                read_src <= mem_select ? SRC_MEM : (key_select ? SRC_KEY : SRC_NONE);
            end
            art_write_d <= art_write;
            // One strobe per write burst
            uart_strobe <= art_write && !art_write_d;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (bus_read_enable && key_select) begin
            key_data <= key_ascii;
        end
        if (art_write && !art_write_d) begin
            uart_data <= bus_write_data[7:0];
        end
    end

    always_comb begin
        case (read_src)
            SRC_MEM: bus_read_data = mem.read_data;
            SRC_KEY: bus_read_data = {56'd0, key_data};
            default: bus_read_data = '0;
        endcase
    end

endmodule

`default_nettype wire

/* src/board_top.sv */
`timescale 1ns/10ps
`default_nettype none

module board_top (
    input  logic                   CLOCK_50,
    input  logic                   KEY0,
    input  logic                   PS2_CLK,
    input  logic                   PS2_DAT,

    // Core fetch side
    input  board_pkg::addr_t       fetch_pc,
    output board_pkg::mem_word_t   instruction,

    // Core data bus
    input  board_pkg::addr_t       bus_address,
    input  board_pkg::word_t       bus_write_data,
    input  logic                   bus_write_enable,
    input  logic                   bus_read_enable,
    output board_pkg::word_t       bus_read_data,

    output board_pkg::irq_vector_t interrupt_vector,
    input  logic                   interrupt_ack,

    // Character output port
    output board_pkg::ascii_t      uart_data,
    output logic                   uart_strobe,

    output logic                   LEDR0,
    output logic                   LEDR1
);

    board_pkg::ascii_t ascii_code;
    board_pkg::ascii_t key_ascii;
    logic              key_pressed;

    bus_if mem_bus ();

    unified_memory memory_inst (
        .CLOCK_50    (CLOCK_50),
        .fetch_pc    (fetch_pc),
        .instruction (instruction),
        .bus         (mem_bus)
    );

    // Raw scan code and release pulse have no consumer on this board
    ps2_keyboard_decoder keyboard_inst (
        .CLOCK_50     (CLOCK_50),
        .KEY0         (KEY0),
        .ps2_clk      (PS2_CLK),
        .ps2_data     (PS2_DAT),
        .scan_code    (),
        .ascii_code   (ascii_code),
        .key_pressed  (key_pressed),
        .key_released ()
    );

    interrupt_controller irq_inst (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .key_pressed      (key_pressed),
        .ascii_code       (ascii_code),
        .interrupt_ack    (interrupt_ack),
        .interrupt_vector (interrupt_vector),
        .key_ascii        (key_ascii),
        .pending_led      (LEDR0)
    );

    mmio_bus_decoder decoder_inst (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .bus_read_data    (bus_read_data),
        .key_ascii        (key_ascii),
        .mem              (mem_bus),
        .uart_data        (uart_data),
        .uart_strobe      (uart_strobe),
        .key_select       (LEDR1)
    );

endmodule

`default_nettype wire

/* verification/tb_board_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "board_config.svh"

module tb_board_top;

    localparam int MAX_TESTS = 64;

    logic                   CLOCK_50 = 1'b0;
    logic                   KEY0;
    logic                   PS2_CLK;
    logic                   PS2_DAT;
    board_pkg::addr_t       fetch_pc;
    board_pkg::mem_word_t   instruction;
    board_pkg::addr_t       bus_address;
    board_pkg::word_t       bus_write_data;
    logic                   bus_write_enable;
    logic                   bus_read_enable;
    board_pkg::word_t       bus_read_data;
    board_pkg::irq_vector_t interrupt_vector;
    logic                   interrupt_ack;
    board_pkg::ascii_t      uart_data;
    logic                   uart_strobe;
    logic                   LEDR0;
    logic                   LEDR1;

    logic [7:0]  test_op       [MAX_TESTS];
    string       test_name     [MAX_TESTS];
    logic [63:0] test_arg0     [MAX_TESTS];
    logic [63:0] test_arg1     [MAX_TESTS];
    logic [63:0] test_arg2     [MAX_TESTS];
    logic [63:0] test_expected [MAX_TESTS];
    int          test_count  = 0;
    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    board_top board_top_inst (.*);

    always #50 CLOCK_50 = ~CLOCK_50;

    task automatic tick();
        @(posedge CLOCK_50);
        #1;
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic load_tests();
        int              fd;
        int              fields;
        string           line;
        logic [63:0]     op_text;
        logic [8*24-1:0] name_text;
        logic [63:0]     a0;
        logic [63:0]     a1;
        logic [63:0]     a2;
        logic [63:0]     ex;
        fd = $fopen("verification/board_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the tests file verification/board_tests.txt");
            error_count++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            fields = $sscanf(line, "%s %s %h %h %h %h", op_text, name_text, a0, a1, a2, ex);
            // Comment lines start with '#' and fail the op test
            if (fields == 6 && test_count < MAX_TESTS && op_text[7:0] inside
                    {"W", "R", "F", "K", "B", "A", "U"}) begin
                test_op[test_count]       = op_text[7:0];
                test_name[test_count]     = $sformatf("%0s", name_text);
                test_arg0[test_count]     = a0;
                test_arg1[test_count]     = a1;
                test_arg2[test_count]     = a2;
                test_expected[test_count] = ex;
                test_count++;
            end
        end
        $fclose(fd);
    endtask

    task automatic bus_write(input logic [63:0] addr, input logic [63:0] data);
        tick();
        bus_address      = addr;
        bus_write_data   = data;
        bus_write_enable = 1'b1;
        tick();
        bus_write_enable = 1'b0;
    endtask

    task automatic bus_read(input string name, input logic [63:0] addr,
                            input logic [63:0] expected);
        tick();
        bus_address     = addr;
        bus_read_enable = 1'b1;
        // LED follows the keyboard address directly
        @(negedge CLOCK_50);
        check_value($sformatf("%s/LEDR1", name), 64'(addr == `KEY_BASE), 64'(LEDR1));
        tick();
        bus_read_enable = 1'b0;
        @(negedge CLOCK_50);
        check_value(name, expected, bus_read_data);
    endtask

    task automatic fetch_pair(input string name, input logic [63:0] pc,
                              input logic [63:0] next_expected, input logic [63:0] expected);
        tick();
        fetch_pc = pc;
        tick();
        fetch_pc = pc + 64'd4;
        @(negedge CLOCK_50);
        check_value(name, expected, 64'(instruction));
        tick();
        @(negedge CLOCK_50);
        check_value($sformatf("%s/next", name), next_expected, 64'(instruction));
    endtask

    // Start, 8 data bits LSB first, odd parity, stop
    task automatic send_ps2_frame(input logic [7:0] code, input logic bad_parity);
        logic [10:0] bits;
        bits = {1'b1, (~^code) ^ bad_parity, code, 1'b0};
        tick();
        for (int b = 0; b < 11; b++) begin
            PS2_DAT = bits[b];
            repeat (20) tick();
            PS2_CLK = 1'b0;
            repeat (20) tick();
            PS2_CLK = 1'b1;
        end
        PS2_DAT = 1'b1;
        repeat (20) tick();
    endtask

    task automatic check_irq(input string name, input logic [63:0] irq_expected);
        @(negedge CLOCK_50);
        check_value($sformatf("%s/vector", name), irq_expected, 64'(interrupt_vector));
        check_value($sformatf("%s/LEDR0", name), 64'(irq_expected != 0), 64'(LEDR0));
    endtask

    task automatic key_test(input string name, input logic [7:0] code, input logic bad_parity,
                            input logic [63:0] irq_expected, input logic [63:0] key_expected);
        int waited;
        send_ps2_frame(code, bad_parity);
        if (irq_expected != 0) begin
            waited = 0;
            while (interrupt_vector == '0 && waited < 200) begin
                tick();
                waited++;
            end
            if (interrupt_vector == '0) begin
                $display("%s: no keyboard interrupt within 200 cycles of the frame", name);
                error_count++;
            end
        end else begin
            repeat (40) tick();
        end
        check_irq(name, irq_expected);
        bus_read($sformatf("%s/key_reg", name), `KEY_BASE, key_expected);
    endtask

    task automatic break_test(input string name, input logic [7:0] code,
                              input logic [63:0] key_expected);
        send_ps2_frame(8'hF0, 1'b0);
        send_ps2_frame(code, 1'b0);
        repeat (40) tick();
        check_irq(name, 64'd0);
        bus_read($sformatf("%s/key_reg", name), `KEY_BASE, key_expected);
    endtask

    task automatic ack_test(input string name, input logic [63:0] expected);
        tick();
        interrupt_ack = 1'b1;
        tick();
        interrupt_ack = 1'b0;
        check_irq(name, expected);
    endtask

    task automatic uart_test(input string name, input logic [63:0] data,
                             input logic [63:0] hold, input logic [63:0] expected);
        int         strobes;
        int         c;
        logic [7:0] seen;
        strobes = 0;
        seen    = '0;
        tick();
        bus_address      = `ART_BASE;
        bus_write_data   = data;
        bus_write_enable = 1'b1;
        // Watch a few cycles past the write for extra strobes
        for (c = 0; c < int'(hold) + 4; c++) begin
            @(negedge CLOCK_50);
            if (uart_strobe) begin
                strobes++;
                seen = uart_data;
            end
            tick();
            if (c == int'(hold) - 1) begin
                bus_write_enable = 1'b0;
            end
        end
        check_value($sformatf("%s/strobes", name), 64'd1, 64'(strobes));
        check_value($sformatf("%s/uart_data", name), expected, 64'(seen));
    endtask

    task automatic run_test(input int i);
        case (test_op[i])
            "W": bus_write(test_arg0[i], test_arg1[i]);
            "R": bus_read(test_name[i], test_arg0[i], test_expected[i]);
            "F": fetch_pair(test_name[i], test_arg0[i], test_arg1[i], test_expected[i]);
            "K": key_test(test_name[i], test_arg0[i][7:0], test_arg1[i][0], test_arg2[i],
                          test_expected[i]);
            "B": break_test(test_name[i], test_arg0[i][7:0], test_expected[i]);
            "A": ack_test(test_name[i], test_expected[i]);
            default: uart_test(test_name[i], test_arg0[i], test_arg1[i], test_expected[i]);
        endcase
    endtask

    // Run limit scales with the number of tests
    initial begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge CLOCK_50);
            cycle_count++;
        end
        $display("Timeout: the run reached its limit of %0d cycles", cycle_limit);
        $display("Test failed");
        $finish;
    end

    initial begin
        KEY0             = 1'b0;
        PS2_CLK          = 1'b1;
        PS2_DAT          = 1'b1;
        fetch_pc         = '0;
        bus_address      = '0;
        bus_write_data   = '0;
        bus_write_enable = 1'b0;
        bus_read_enable  = 1'b0;
        interrupt_ack    = 1'b0;
        load_tests();
        if (test_count == 0) begin
            $display("No tests were read from the tests file");
            error_count++;
        end
        cycle_limit = 400 * test_count + 100;
        repeat (5) @(posedge CLOCK_50);
        #1;
        KEY0 = 1'b1;
        @(negedge CLOCK_50);
        check_value("reset/uart_strobe", 64'd0, 64'(uart_strobe));
        check_value("reset/vector", 64'd0, 64'(interrupt_vector));
        check_value("reset/LEDR0", 64'd0, 64'(LEDR0));
        for (int i = 0; i < test_count; i++) begin
            run_test(i);
        end
        $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+src
src/board_pkg.sv
src/bus_if.sv
src/unified_memory.sv
src/ps2_keyboard_decoder.sv
src/interrupt_controller.sv
src/mmio_bus_decoder.sv
src/board_top.sv
verification/tb_board_top.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_board_top -f compile.f -o tb_board_top \
    && ./obj_dir/tb_board_top > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* verification/board_tests.txt */
# op name arg0 arg1 arg2 expected, all numbers in hex
# W addr data | R addr exp | F pc next_exp exp | K code badpar irq reg | B code reg | A vec | U data hold byte
W wr_rom0 0 11223344 0 0
W wr_rom1 4 aabbccdd 0 0
W wr_ram0 1000 cafef00ddeadbeef 0 0
W wr_top ffc 0badf00d 0 0
R rd_rom0 0 0 0 11223344
R rd_rom1 4 0 0 aabbccdd
R rd_ram0 1000 0 0 deadbeef
R rd_top ffc 0 0 0badf00d
R rd_unmapped 3000 0 0 0
R rd_art 2000 0 0 0
F fetch_rom 0 ddccbbaa 0 44332211
F fetch_ram 1000 0 0 efbeadde
U uart_one 5a5a5a41 1 0 41
U uart_hold 1230000042 3 0 42
R rd_rom0_kept 0 0 0 11223344
K key_a 1c 0 1 61
R rd_key 2008 0 0 61
A ack_a 0 0 0 0
K key_z 1a 0 1 7a
A ack_z 0 0 0 0
B break_a 1c 0 0 7a
K key_f1 05 0 0 7a
K bad_parity 1c 1 0 7a
R rd_key_kept 2008 0 0 7a
K key_digit 16 0 1 31
A ack_digit 0 0 0 0
